// ==== design/adc_acq_macros.svh ====
`ifndef ADC_ACQ_MACROS_SVH
`define ADC_ACQ_MACROS_SVH

//////////////////////////////////////////////////
// data path widths

// packed sample pair: two 12-bit samples plus two over-range bits
`define ADC_WORD_W      26
// circular buffer address width, 256 entries
`define ADC_CBUF_AW     8
// output word: 4-bit tag plus 128-bit payload
`define ADC_OUT_W       132

//////////////////////////////////////////////////
// readout sizing

`define ADC_TRIG_DEPTH  4    // queued trigger addresses
`define ADC_BURST_WORDS 4    // packed words per data word
`define ADC_NBURST_W    14   // burst count width
`define ADC_OUT_CREDITS 4    // downstream credits after reset

`endif

// ==== design/adc_acq_pkg.sv ====
package adc_acq_pkg;

    // readout controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_POP_TRIG,      // take trigger address from the queue
        ST_START_ADDR,    // load read counter with pre-trigger start
        ST_SEND_HDR,
        ST_READ_BURST,    // four back-to-back buffer reads
        ST_SEND_DATA,
        ST_SEND_SUM,
        ST_DONE
    } acq_state_t;

    // opcode carried in out_dat[131:128]
    typedef enum logic [3:0] {
        TAG_WFM_HDR  = 4'd1,
        TAG_DATA     = 4'd2,
        TAG_CHECKSUM = 4'd3
    } frame_tag_t;

endpackage

// ==== design/adc_circ_buf.sv ====
`timescale 1ns/10ps
`include "adc_acq_macros.svh"

module adc_circ_buf (
    input  logic                    adc_clk,
    input  logic                    rst,
    input  logic                    wr_en,     // capture enabled
    input  logic [`ADC_WORD_W-1:0]  wr_dat,    // packed sample pair
    input  logic [`ADC_CBUF_AW-1:0] rd_addr,
    output logic [`ADC_WORD_W-1:0]  rd_dat,    // one cycle after rd_addr
    output logic [`ADC_CBUF_AW-1:0] wr_addr    // address being written this cycle
);

    localparam int DEPTH = 1 << `ADC_CBUF_AW;

    logic [`ADC_WORD_W-1:0] mem [DEPTH];

    //////////////////////////////////////////////////
    // write address, wraps around the buffer

    always_ff @(posedge adc_clk) begin
        if (rst)
            wr_addr <= '0;
        else if (wr_en)
            wr_addr <= wr_addr + 1'b1;   // natural wrap at 256
    end

    //////////////////////////////////////////////////
    // dual-port memory, registered read

    always_ff @(posedge adc_clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_dat;
        rd_dat <= mem[rd_addr];          // read-before-write on collision
    end

endmodule

// ==== design/trig_addr_fifo.sv ====
`timescale 1ns/10ps
`include "adc_acq_macros.svh"

module trig_addr_fifo (
    input  logic                    adc_clk,
    input  logic                    rst,
    input  logic                    push,       // gated trigger pulse
    input  logic [`ADC_CBUF_AW-1:0] push_addr,  // write address at trigger
    input  logic                    pop,
    output logic [`ADC_CBUF_AW-1:0] head_addr,  // oldest entry, valid when not empty
    output logic                    empty
);

    localparam int PTR_W = $clog2(`ADC_TRIG_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = `ADC_TRIG_DEPTH;

    logic [`ADC_CBUF_AW-1:0] mem [`ADC_TRIG_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count;      // occupancy, 0 to depth
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign full      = (count == FULL_CNT);
    assign empty     = (count == '0);
    assign do_push   = push && !full;    // trigger lost when queue is full
    assign do_pop    = pop && !empty;
    assign head_addr = mem[rd_ptr];      // fall-through head

    //////////////////////////////////////////////////
    // pointers and occupancy

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage, no reset needed
    always_ff @(posedge adc_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_addr;
    end

endmodule

// ==== design/acq_ctrl_sm.sv ====
`timescale 1ns/10ps
`include "adc_acq_macros.svh"

module acq_ctrl_sm (
    input  logic                      adc_clk,
    input  logic                      rst,
    input  logic                      acq_enable,          // capture running
    input  logic                      acq_trig,            // one-cycle trigger
    input  logic                      trig_empty,
    input  logic [`ADC_CBUF_AW-1:0]   trig_head_addr,
    input  logic [`ADC_NBURST_W-1:0]  num_bursts,
    input  logic [`ADC_CBUF_AW-1:0]   pre_trig,
    input  logic [23:0]               initial_fill_num,
    input  logic                      initial_fill_num_wr,
    input  logic                      out_credit,          // one credit returned
    output logic                      trig_push,
    output logic                      trig_pop,
    output logic [`ADC_CBUF_AW-1:0]   rd_addr,
    output logic                      latch_dat,           // rd_dat valid, shift it in
    output logic                      sum_clear,
    output adc_acq_pkg::frame_tag_t   word_sel,
    output logic [`ADC_CBUF_AW-1:0]   trig_addr,
    output logic [23:0]               fill_num,
    output logic                      out_valid,
    output logic                      acq_done,
    output logic                      sm_idle
);
    import adc_acq_pkg::*;

    localparam int WCNT_W = $clog2(`ADC_BURST_WORDS);
    localparam int CRED_W = $clog2(`ADC_OUT_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_INIT = `ADC_OUT_CREDITS;

    acq_state_t               state;
    acq_state_t               state_nxt;
    logic [`ADC_CBUF_AW-1:0]  start_addr;   // trigger address minus pre_trig
    logic [`ADC_NBURST_W-1:0] burst_cnt;    // bursts still to send
    logic [WCNT_W-1:0]        word_cnt;     // reads issued in this burst
    logic [CRED_W-1:0]        credit_cnt;
    logic                     has_credit;
    logic                     rd_issue;
    logic                     last_word;
    logic                     last_burst;

    assign trig_push  = acq_trig && acq_enable;   // no triggers while capture is off
    assign trig_pop   = (state == ST_POP_TRIG);
    assign sum_clear  = (state == ST_START_ADDR);
    assign acq_done   = (state == ST_DONE);
    assign sm_idle    = (state == ST_IDLE);
    assign rd_issue   = (state == ST_READ_BURST);
    assign has_credit = (credit_cnt != '0);
    assign last_word  = &word_cnt;                      // burst length is a power of two
    assign last_burst = (burst_cnt[`ADC_NBURST_W-1:1] == '0);   // count is 0 or 1

    //////////////////////////////////////////////////
    // word select and qualifier

    always_comb begin
        case (state)
            ST_SEND_HDR: word_sel = TAG_WFM_HDR;
            ST_SEND_SUM: word_sel = TAG_CHECKSUM;
            default:     word_sel = TAG_DATA;
        endcase
    end

    always_comb begin
        case (state)
            ST_SEND_HDR, ST_SEND_SUM: out_valid = has_credit;
            ST_SEND_DATA:             out_valid = has_credit && !latch_dat;  // last word still landing
            default:                  out_valid = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // next state, word states hold without credit

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (!trig_empty)
                    state_nxt = ST_POP_TRIG;
            end
            ST_POP_TRIG:   state_nxt = ST_START_ADDR;
            ST_START_ADDR: state_nxt = ST_SEND_HDR;
            ST_SEND_HDR: begin
                if (out_valid)
                    state_nxt = ST_READ_BURST;
            end
            ST_READ_BURST: begin
                if (last_word)
                    state_nxt = ST_SEND_DATA;
            end
            ST_SEND_DATA: begin
                if (out_valid)
                    state_nxt = last_burst ? ST_SEND_SUM : ST_READ_BURST;
            end
            ST_SEND_SUM: begin
                if (out_valid)
                    state_nxt = ST_DONE;
            end
            default: state_nxt = ST_IDLE;   // ST_DONE, one cycle
        endcase
    end

    //////////////////////////////////////////////////
    // control registers

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            latch_dat <= 1'b0;
            word_cnt  <= '0;
            burst_cnt <= '0;
        end else begin
            state     <= state_nxt;
            latch_dat <= rd_issue;              // read port latency of one
            if (rd_issue)
                word_cnt <= word_cnt + 1'b1;    // wraps back to 0 after the burst
            if (state == ST_START_ADDR)
                burst_cnt <= num_bursts;
            else if (state == ST_SEND_DATA && out_valid)
                burst_cnt <= burst_cnt - 1'b1;
        end
    end

    // credits: take on valid, give back on out_credit
    always_ff @(posedge adc_clk) begin
        if (rst)
            credit_cnt <= CRED_INIT;
        else if (out_valid && !out_credit)
            credit_cnt <= credit_cnt - 1'b1;
        else if (out_credit && !out_valid && credit_cnt != CRED_INIT)
            credit_cnt <= credit_cnt + 1'b1;    // saturate at the initial count
    end

    always_ff @(posedge adc_clk) begin
        if (rst)
            fill_num <= '0;
        else if (initial_fill_num_wr)
            fill_num <= initial_fill_num;
        else if (acq_done)
            fill_num <= fill_num + 1'b1;        // one per waveform
    end

    //////////////////////////////////////////////////
    // addresses

    always_ff @(posedge adc_clk) begin
        if (trig_pop) begin
            trig_addr  <= trig_head_addr;
            start_addr <= trig_head_addr - pre_trig;   // wraps in the ring
        end
        if (state == ST_START_ADDR)
            rd_addr <= start_addr;
        else if (rd_issue)
            rd_addr <= rd_addr + 1'b1;
    end

endmodule

// ==== design/acq_frame_mux.sv ====
`timescale 1ns/10ps
`include "adc_acq_macros.svh"

module acq_frame_mux (
    input  logic                      adc_clk,
    input  logic                      rst,
    input  logic [`ADC_WORD_W-1:0]    rd_dat,       // buffer read data
    input  logic                      latch_dat,
    input  logic                      sum_clear,    // start of waveform
    input  adc_acq_pkg::frame_tag_t   word_sel,
    input  logic                      out_valid,
    input  logic [11:0]               channel_tag,
    input  logic [23:0]               fill_num,
    input  logic [`ADC_NBURST_W-1:0]  num_bursts,
    input  logic [`ADC_CBUF_AW-1:0]   trig_addr,
    output logic [`ADC_OUT_W-1:0]     out_dat
);
    import adc_acq_pkg::*;

    localparam int TAG_W     = $bits(frame_tag_t);
    localparam int PAY_W     = `ADC_OUT_W - TAG_W;   // 128
    localparam int HDR_PAD_W = 78 - `ADC_CBUF_AW;    // zero gap in bits 77:8

    logic [`ADC_WORD_W-1:0] shift_q [`ADC_BURST_WORDS];
    logic [PAY_W-1:0]       data_pay;
    logic [PAY_W-1:0]       hdr_pay;
    logic [PAY_W-1:0]       sum_q;      // running XOR of data payloads
    logic [PAY_W-1:0]       pay;

    //////////////////////////////////////////////////
    // burst shift register
    // newest word enters at the top, first read ends in slot 0

    always_ff @(posedge adc_clk) begin
        if (latch_dat) begin
            shift_q[`ADC_BURST_WORDS-1] <= rd_dat;
            for (int i = 0; i < `ADC_BURST_WORDS - 1; i++)
                shift_q[i] <= shift_q[i+1];
        end
    end

    always_comb begin
        data_pay = '0;                          // upper bits stay zero
        for (int i = 0; i < `ADC_BURST_WORDS; i++)
            data_pay[i*`ADC_WORD_W +: `ADC_WORD_W] = shift_q[i];
    end

    // header: tag 127:116, fill 115:92, bursts 91:78, trig addr at the bottom
    assign hdr_pay = {channel_tag, fill_num, num_bursts, {HDR_PAD_W{1'b0}}, trig_addr};

    //////////////////////////////////////////////////
    // checksum accumulator

    always_ff @(posedge adc_clk) begin
        if (rst || sum_clear)
            sum_q <= '0;
        else if (out_valid && word_sel == TAG_DATA)
            sum_q <= sum_q ^ data_pay;          // only words actually sent
    end

    always_comb begin
        case (word_sel)
            TAG_WFM_HDR:  pay = hdr_pay;
            TAG_CHECKSUM: pay = sum_q;
            default:      pay = data_pay;
        endcase
    end

    assign out_dat = {word_sel, pay};   // opcode in the top nibble

endmodule

// ==== design/adc_acq_top.sv ====
`timescale 1ns/10ps
`include "adc_acq_macros.svh"

module adc_acq_top (
    input  logic                      adc_clk,
    input  logic                      rst,
    input  logic [`ADC_WORD_W-1:0]    sample_dat,          // packed sample pair
    input  logic                      acq_enable,
    input  logic                      acq_trig,            // one-cycle pulse
    input  logic [11:0]               channel_tag,
    input  logic [23:0]               initial_fill_num,
    input  logic                      initial_fill_num_wr,
    input  logic [`ADC_NBURST_W-1:0]  num_bursts,
    input  logic [`ADC_CBUF_AW-1:0]   pre_trig,
    input  logic                      out_credit,
    output logic [`ADC_OUT_W-1:0]     out_dat,
    output logic                      out_valid,
    output logic [23:0]               fill_num,
    output logic                      acq_done,
    output logic                      sm_idle
);
    import adc_acq_pkg::*;

    logic [`ADC_CBUF_AW-1:0] wr_addr;       // current capture address
    logic [`ADC_CBUF_AW-1:0] rd_addr;
    logic [`ADC_WORD_W-1:0]  rd_dat;
    logic [`ADC_CBUF_AW-1:0] head_addr;     // oldest queued trigger
    logic [`ADC_CBUF_AW-1:0] trig_addr;     // trigger of the waveform in flight
    logic                    trig_push;
    logic                    trig_pop;
    logic                    trig_empty;
    logic                    latch_dat;
    logic                    sum_clear;
    frame_tag_t              word_sel;

    //////////////////////////////////////////////////
    // capture side

    adc_circ_buf i_cbuf (
        .adc_clk (adc_clk),
        .rst     (rst),
        .wr_en   (acq_enable),
        .wr_dat  (sample_dat),
        .rd_addr (rd_addr),
        .rd_dat  (rd_dat),
        .wr_addr (wr_addr)
    );

    trig_addr_fifo i_trig_fifo (
        .adc_clk   (adc_clk),
        .rst       (rst),
        .push      (trig_push),
        .push_addr (wr_addr),       // address written in the trigger cycle
        .pop       (trig_pop),
        .head_addr (head_addr),
        .empty     (trig_empty)
    );

    //////////////////////////////////////////////////
    // readout side

    acq_ctrl_sm i_ctrl (
        .adc_clk             (adc_clk),
        .rst                 (rst),
        .acq_enable          (acq_enable),
        .acq_trig            (acq_trig),
        .trig_empty          (trig_empty),
        .trig_head_addr      (head_addr),
        .num_bursts          (num_bursts),
        .pre_trig            (pre_trig),
        .initial_fill_num    (initial_fill_num),
        .initial_fill_num_wr (initial_fill_num_wr),
        .out_credit          (out_credit),
        .trig_push           (trig_push),
        .trig_pop            (trig_pop),
        .rd_addr             (rd_addr),
        .latch_dat           (latch_dat),
        .sum_clear           (sum_clear),
        .word_sel            (word_sel),
        .trig_addr           (trig_addr),
        .fill_num            (fill_num),
        .out_valid           (out_valid),
        .acq_done            (acq_done),
        .sm_idle             (sm_idle)
    );

    acq_frame_mux i_mux (
        .adc_clk     (adc_clk),
        .rst         (rst),
        .rd_dat      (rd_dat),
        .latch_dat   (latch_dat),
        .sum_clear   (sum_clear),
        .word_sel    (word_sel),
        .out_valid   (out_valid),
        .channel_tag (channel_tag),
        .fill_num    (fill_num),
        .num_bursts  (num_bursts),
        .trig_addr   (trig_addr),
        .out_dat     (out_dat)
    );

endmodule

// ==== bench/adc_acq_tb.sv ====
`timescale 1ns/10ps
`include "adc_acq_macros.svh"

module adc_acq_tb;
    import adc_acq_pkg::*;

    localparam int NROWS   = 5;
    localparam int TMO     = 4000;                  // cycles allowed for any one wait
    localparam int CREDITS = `ADC_OUT_CREDITS;

    //////////////////////////////////////////////////
    // test table with one row per test
    // fill of -1 keeps the running count
    string row_name  [NROWS] = '{"one_burst", "eight_bursts", "queued_three",
                                 "slow_credit", "acq_off"};
    bit    row_en    [NROWS] = '{1, 1, 1, 1, 0};
    int    row_nb    [NROWS] = '{1, 8, 3, 4, 2};
    int    row_pre   [NROWS] = '{32, 64, 40, 48, 32};
    int    row_ntrig [NROWS] = '{1, 1, 3, 2, 2};
    int    row_dmin  [NROWS] = '{0, 0, 1, 6, 0};    // credit return delay range
    int    row_dmax  [NROWS] = '{0, 3, 5, 12, 0};
    int    row_fill  [NROWS] = '{-1, 'h00_1000, -1, 'hff_fffe, -1};

    logic                     adc_clk = 1'b0;
    logic                     rst;
    logic [`ADC_WORD_W-1:0]   sample_dat = '0;
    logic                     acq_enable;
    logic                     acq_trig;
    logic [11:0]              channel_tag;
    logic [23:0]              initial_fill_num;
    logic                     initial_fill_num_wr;
    logic [`ADC_NBURST_W-1:0] num_bursts;
    logic [`ADC_CBUF_AW-1:0]  pre_trig;
    logic                     out_credit = 1'b0;
    logic [`ADC_OUT_W-1:0]    out_dat;
    logic                     out_valid;
    logic [23:0]              fill_num;
    logic                     acq_done;
    logic                     sm_idle;

    // reference model state
    logic [`ADC_WORD_W-1:0]   model [1 << `ADC_CBUF_AW];
    logic [`ADC_CBUF_AW-1:0]  wr_cnt = '0;          // mirrors the capture address
    logic [`ADC_CBUF_AW-1:0]  exp_trig_q [$];       // trigger addresses in order
    logic [`ADC_OUT_W-1:0]    rx_q [$];             // words seen on out_valid
    logic [3:0]               last_tag = '0;
    logic [31:0]              lfsr_q = 32'h1303_dd0c;
    logic [23:0]              exp_fill = '0;
    string                    cur_name = "reset";
    int outstanding = 0;
    int wait_cnt    = 0;
    int done_cnt    = 0;
    int wfm_cnt     = 0;
    int dly_min     = 0;
    int dly_max     = 0;
    int errors      = 0;
    int mon_errors  = 0;
    int timeouts    = 0;
    int checks      = 0;

    adc_acq_top i_dut (.*);

    initial begin
        forever #2 adc_clk = ~adc_clk;              // 4 ns period
    end

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};        // one step per bit
        end
    endtask

    //////////////////////////////////////////////////
    // buffer model, output capture and credit return

    always @(posedge adc_clk) begin
        logic [31:0] bits;
        if (!rst) begin
            if (acq_enable) begin
                model[wr_cnt] = sample_dat;
                if (acq_trig)
                    exp_trig_q.push_back(wr_cnt);   // address written in the trigger cycle
                wr_cnt = wr_cnt + 1'b1;
            end
            if (out_valid) begin
                assert (!sm_idle) else begin
                    $display("%s: out_valid raised while the controller reports idle",
                             cur_name);
                    mon_errors++;
                end
                rx_q.push_back(out_dat);
                last_tag = out_dat[131:128];
                outstanding++;
            end
            if (out_credit)
                outstanding--;                      // pulse taken at this edge
            assert (outstanding <= CREDITS) else begin
                $display("Error %s credits: expected at most %0d, actual %0d",
                         cur_name, CREDITS, outstanding);
                mon_errors++;
            end
            if (acq_done) begin
                assert (last_tag == TAG_CHECKSUM) else begin
                    $display("Error %s acq_done: expected tag %0d, actual tag %0d",
                             cur_name, TAG_CHECKSUM, last_tag);
                    mon_errors++;
                end
                last_tag = '0;                      // a second pulse would fail
                done_cnt++;
            end
            out_credit <= 1'b0;
            if (wait_cnt > 0)
                wait_cnt--;
            else if (outstanding > 0) begin
                out_credit <= 1'b1;
                draw_bits(8, bits);
                wait_cnt = dly_min + int'(bits[7:0]) % (dly_max - dly_min + 1);
            end
        end
        draw_bits(`ADC_WORD_W, bits);
        sample_dat <= bits[`ADC_WORD_W-1:0];
    end

    task automatic compare_word(input string name, input string what,
                                input logic [`ADC_OUT_W-1:0] exp,
                                input logic [`ADC_OUT_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("Error %s %s: expected %h, actual %h", name, what, exp, got);
            errors++;
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        acq_state_t st;
        st = acq_state_t'(i_dut.i_ctrl.state);
        $display("%s: timed out waiting for %s, controller in %s", name, what, st.name());
        timeouts++;
    endtask

    //////////////////////////////////////////////////
    // one waveform of header, data words, checksum and done

    task automatic check_waveform(input int r);
        logic [`ADC_OUT_W-1:0]   exp;
        logic [127:0]            sum;
        logic [`ADC_CBUF_AW-1:0] trig;
        logic [`ADC_CBUF_AW-1:0] addr;
        int                      nb;
        int                      t;
        nb = row_nb[r];
        t  = 0;
        while (rx_q.size() < nb + 2 && t < TMO) begin
            @(negedge adc_clk);
            t++;
        end
        if (rx_q.size() < nb + 2) begin
            report_timeout(row_name[r], "waveform words");
            return;
        end
        assert (exp_trig_q.size() != 0) else begin
            $display("%s: waveform read out with no trigger recorded", row_name[r]);
            errors++;
        end
        trig = (exp_trig_q.size() != 0) ? exp_trig_q.pop_front() : '0;
        exp = '0;
        exp[131:128] = TAG_WFM_HDR;
        exp[127:116] = channel_tag;
        exp[115:92]  = exp_fill;
        exp[91:78]   = num_bursts;
        exp[7:0]     = trig;
        compare_word(row_name[r], "header", exp, rx_q.pop_front());
        sum = '0;
        for (int b = 0; b < nb; b++) begin
            exp = '0;
            exp[131:128] = TAG_DATA;
            for (int k = 0; k < `ADC_BURST_WORDS; k++) begin
                addr = trig - pre_trig + 8'(b * `ADC_BURST_WORDS + k);  // wraps in the ring
                exp[k*`ADC_WORD_W +: `ADC_WORD_W] = model[addr];
            end
            sum = sum ^ exp[127:0];
            compare_word(row_name[r], "data", exp, rx_q.pop_front());
        end
        exp = '0;
        exp[131:128] = TAG_CHECKSUM;
        exp[127:0]   = sum;
        compare_word(row_name[r], "checksum", exp, rx_q.pop_front());
        wfm_cnt++;
        t = 0;
        while (done_cnt < wfm_cnt && t < TMO) begin
            @(negedge adc_clk);
            t++;
        end
        if (done_cnt < wfm_cnt)
            report_timeout(row_name[r], "acq_done");
        exp_fill = exp_fill + 1'b1;
        @(negedge adc_clk);
        compare_word(row_name[r], "fill_num", 132'(exp_fill), 132'(fill_num));
    endtask

    task automatic run_row(input int r);
        cur_name     = row_name[r];
        dly_min      = row_dmin[r];
        dly_max      = row_dmax[r];
        @(posedge adc_clk);
        num_bursts  <= 14'(row_nb[r]);
        pre_trig    <= 8'(row_pre[r]);
        channel_tag <= 12'(12'h5a0 + r);
        if (row_fill[r] >= 0) begin
            initial_fill_num    <= 24'(row_fill[r]);
            initial_fill_num_wr <= 1'b1;
            exp_fill             = 24'(row_fill[r]);
            @(posedge adc_clk);
            initial_fill_num_wr <= 1'b0;
            @(negedge adc_clk);
            compare_word(row_name[r], "loaded fill_num", 132'(exp_fill), 132'(fill_num));
            @(posedge adc_clk);
        end
        acq_enable <= row_en[r];
        repeat (80) @(posedge adc_clk);             // enough history for any pre_trig
        for (int k = 0; k < row_ntrig[r]; k++) begin
            acq_trig <= 1'b1;
            @(posedge adc_clk);
            acq_trig <= 1'b0;
            repeat (6) @(posedge adc_clk);
        end
        acq_enable <= 1'b0;                         // freeze the ring before readout wraps
        if (row_en[r]) begin
            for (int k = 0; k < row_ntrig[r]; k++)
                check_waveform(r);
        end else begin
            repeat (40) begin
                @(negedge adc_clk);
                assert (sm_idle && !out_valid) else begin
                    $display("%s: controller left idle with capture disabled", row_name[r]);
                    errors++;
                end
            end
        end
        assert (rx_q.size() == 0 && exp_trig_q.size() == 0) else begin
            $display("%s: %0d extra words, %0d triggers never read out",
                     row_name[r], rx_q.size(), exp_trig_q.size());
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int t;
        rst                 <= 1'b1;
        acq_enable          <= 1'b0;
        acq_trig            <= 1'b0;
        channel_tag         <= '0;
        initial_fill_num    <= '0;
        initial_fill_num_wr <= 1'b0;
        num_bursts          <= 14'd1;
        pre_trig            <= 8'd32;
        repeat (10) @(posedge adc_clk);
        rst <= 1'b0;
        for (int r = 0; r < NROWS; r++)
            run_row(r);
        t = 0;
        while (outstanding != 0 && t < TMO) begin   // all credits back
            @(negedge adc_clk);
            t++;
        end
        if (outstanding != 0)
            report_timeout("final", "credit return");
        $display("checks %0d, errors %0d, monitor errors %0d, timeouts %0d",
                 checks, errors, mon_errors, timeouts);
        if (errors + mon_errors + timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+design
design/adc_acq_pkg.sv
design/adc_circ_buf.sv
design/trig_addr_fifo.sv
design/acq_ctrl_sm.sv
design/acq_frame_mux.sv
design/adc_acq_top.sv
bench/adc_acq_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP      := adc_acq_tb
FILELIST := list.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
